//--- src/memCtrl_defs.svh
`ifndef MEMCTRL_DEFS_SVH
`define MEMCTRL_DEFS_SVH

// cpu side address bus
`define MEM_ADDR_W 32

// instruction and load/store word
`define MEM_DATA_W 32

// width of one ram location
`define BYTE_W 8

// ram index bits, low address bits only
`define RAM_ADDR_W 12

// number of ram locations, 4 KiB
`define RAM_DEPTH (1 << `RAM_ADDR_W)

`endif

//--- src/memCtrlPkg.sv
`include "memCtrl_defs.svh"

package memCtrlPkg;

    // who holds the memory port
    typedef enum logic [1:0] {
        OWN_IDLE  = 2'd0,
        OWN_FETCH = 2'd1,
        OWN_DATA  = 2'd2
    } memOwner_t;

    // byte count of a transfer, 1, 2 or 4
    typedef logic [2:0] memLen_t;

    // fetches always move a full word
    localparam memLen_t LEN_WORD = 3'd4;

    // load/store request, also the latched request in the arbiter
    typedef struct packed {
        logic                   isStore;
        memLen_t                len;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } memReq_t;

    // one byte access toward the ram
    typedef struct packed {
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`BYTE_W-1:0]     wdata;
    } ramPort_t;

endpackage

//--- src/memArbiter.sv
`timescale 1ns/10ps
`include "memCtrl_defs.svh"

module memArbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   fetchEn,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    input  logic                   dataEn,
    input  memCtrlPkg::memReq_t    dataReq,
    input  logic                   seqFinish,
    input  logic [`MEM_DATA_W-1:0] seqRdata,
    output logic                   start,
    output memCtrlPkg::memReq_t    curReq,
    output logic                   fetchDone,
    output logic [`MEM_DATA_W-1:0] fetchInst,
    output logic                   dataDone,
    output logic [`MEM_DATA_W-1:0] dataRdata,
    output memCtrlPkg::memOwner_t  busy
);
    memCtrlPkg::memReq_t fetchReq;
    logic                accept;
    logic                finishFetch;
    logic                finishData;

    // fetch is a plain 4-byte load
    always_comb begin
        fetchReq.isStore = 1'b0;
        fetchReq.len     = memCtrlPkg::LEN_WORD;
        fetchReq.addr    = fetchAddr;
        fetchReq.wdata   = '0;
    end

    // en of a request that just got done is still high, so skip that cycle
    assign accept = advance && (busy == memCtrlPkg::OWN_IDLE) && !fetchDone && !dataDone
                    && (dataEn || fetchEn);

    assign finishFetch = advance && seqFinish && (busy == memCtrlPkg::OWN_FETCH);
    assign finishData  = advance && seqFinish && (busy == memCtrlPkg::OWN_DATA);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= memCtrlPkg::OWN_IDLE;
            start <= 1'b0;
        end else if (advance) begin
            start <= 1'b0;
            if (seqFinish && busy != memCtrlPkg::OWN_IDLE) begin
                busy <= memCtrlPkg::OWN_IDLE;
            end else if (accept) begin
                // data port wins
                busy  <= dataEn ? memCtrlPkg::OWN_DATA : memCtrlPkg::OWN_FETCH;
                start <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            curReq <= dataEn ? dataReq : fetchReq;
        end
    end

    // done is a single cycle pulse, also across a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= finishFetch;
            dataDone  <= finishData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchInst <= '0;
            dataRdata <= '0;
        end else begin
            if (finishFetch) begin
                fetchInst <= seqRdata;
            end
            if (finishData) begin
                dataRdata <= seqRdata;
            end
        end
    end

endmodule

//--- src/byteSequencer.sv
`timescale 1ns/10ps
`include "memCtrl_defs.svh"

module byteSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   start,
    input  memCtrlPkg::memReq_t    req,
    input  logic [`BYTE_W-1:0]     ramRdata,
    output memCtrlPkg::ramPort_t   ram,
    output logic                   finish,
    output logic [`MEM_DATA_W-1:0] rdata
);
    logic                   active;
    logic                   inXfer;
    logic                   issuing;
    logic                   capture;
    logic [2:0]             stage;
    logic [2:0]             ramIdx;
    logic [2:0]             lastIdx;
    logic [1:0]             capLane;
    logic [`MEM_DATA_W-1:0] assembly;
    logic [`MEM_DATA_W-1:0] loadWord;

    // start covers the first byte, active the rest
    assign inXfer  = start || active;

    // stage counts byte addresses already issued
    assign issuing = inXfer && (stage < req.len);
    assign lastIdx = req.len - 3'd1;

    // stores end on the last write, loads once the last byte is back
    always_comb begin
        if (req.isStore) begin
            finish = inXfer && (stage == lastIdx);
        end else begin
            finish = inXfer && (stage == req.len);
        end
    end

    // the ram registers its output every cycle, so while frozen it is
    // pointed back at the byte already sitting in ramRdata
    always_comb begin
        if (!advance) begin
            ramIdx = stage - 3'd1;
        end else begin
            ramIdx = stage;
        end
    end

    always_comb begin
        ram.write = issuing && req.isStore && advance;
        ram.addr  = req.addr + {{(`MEM_ADDR_W - 3){1'b0}}, ramIdx};
        ram.wdata = req.wdata[`BYTE_W * stage[1:0] +: `BYTE_W];
    end

    // byte returned now belongs to the previous stage
    assign capLane = stage[1:0] - 2'd1;
    assign capture = inXfer && !req.isStore && (stage != 3'd0) && !finish;

    // last byte comes straight from the ram, upper lanes stay zero
    always_comb begin
        loadWord = assembly;
        loadWord[`BYTE_W * lastIdx[1:0] +: `BYTE_W] = ramRdata;
    end

    assign rdata = req.isStore ? '0 : loadWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            stage  <= 3'd0;
        end else if (advance) begin
            if (finish) begin
                active <= 1'b0;
                stage  <= 3'd0;
            end else if (inXfer) begin
                active <= 1'b1;
                if (issuing) begin
                    stage <= stage + 3'd1;
                end
            end
        end
    end

    // cleared after every transfer for zero extension
    always_ff @(posedge clk) begin
        if (rst) begin
            assembly <= '0;
        end else if (advance) begin
            if (finish) begin
                assembly <= '0;
            end else if (capture) begin
                assembly[`BYTE_W * capLane +: `BYTE_W] <= ramRdata;
            end
        end
    end

endmodule

//--- src/byteRam.sv
`timescale 1ns/10ps
`include "memCtrl_defs.svh"

module byteRam (
    input  logic                 clk,
    input  memCtrlPkg::ramPort_t ram,
    output logic [`BYTE_W-1:0]   rdata
);
    logic [`BYTE_W-1:0]     mem [`RAM_DEPTH];
    logic [`RAM_ADDR_W-1:0] index;

    // address wraps inside the ram
    assign index = ram.addr[`RAM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (ram.write) begin
            mem[index] <= ram.wdata;
        end
    end

    // one cycle read latency, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

//--- src/memSubsystem.sv
`timescale 1ns/10ps
`include "memCtrl_defs.svh"

module memSubsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,
    input  logic                   fetchEn,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    output logic                   fetchDone,
    output logic [`MEM_DATA_W-1:0] fetchInst,
    input  logic                   dataEn,
    input  memCtrlPkg::memReq_t    dataReq,
    output logic                   dataDone,
    output logic [`MEM_DATA_W-1:0] dataRdata,
    output memCtrlPkg::memOwner_t  busy
);
    logic                   advance;
    logic                   start;
    memCtrlPkg::memReq_t    curReq;
    logic                   seqFinish;
    logic [`MEM_DATA_W-1:0] seqRdata;
    memCtrlPkg::ramPort_t   ramPort;
    logic [`BYTE_W-1:0]     ramRdata;

    // whole controller freezes on either condition
    assign advance = rdy && !ioBufferFull;

    memArbiter arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .seqFinish (seqFinish),
        .seqRdata  (seqRdata),
        .start     (start),
        .curReq    (curReq),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .busy      (busy)
    );

    byteSequencer sequencer_i (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .start    (start),
        .req      (curReq),
        .ramRdata (ramRdata),
        .ram      (ramPort),
        .finish   (seqFinish),
        .rdata    (seqRdata)
    );

    byteRam ram_i (
        .clk   (clk),
        .ram   (ramPort),
        .rdata (ramRdata)
    );

endmodule

//--- verif/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on a rising edge, the DUT still samples it high there
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verif/memChecker.sv
`timescale 1ns/10ps
`include "memCtrl_defs.svh"

module memChecker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,
    input  logic                   dataEn,
    input  memCtrlPkg::memReq_t    dataReq,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    input  logic                   fetchDone,
    input  logic [`MEM_DATA_W-1:0] fetchInst,
    input  logic                   dataDone,
    input  logic [`MEM_DATA_W-1:0] dataRdata,
    input  memCtrlPkg::memOwner_t  busy,
    input  logic [127:0]           testName,
    input  int                     expDataCycle,
    input  int                     expFetchCycle,
    output int                     errorCount
);
    logic [`BYTE_W-1:0]    refMem [`RAM_DEPTH];
    memCtrlPkg::memReq_t   xfer;
    memCtrlPkg::memOwner_t owner;
    memCtrlPkg::memOwner_t lastBusy = memCtrlPkg::OWN_IDLE;
    logic [127:0]          xferName;
    logic                  pending = 1'b0;
    logic                  lastRst = 1'b0;
    logic                  lastAdvance = 1'b0;
    int                    xferCycles = 0;
    int                    xferExp = 0;
    int                    resetEdges = 0;
    int                    errors = 0;

    assign errorCount = errors;

    // little-endian word from the reference, upper lanes zero
    function automatic logic [`MEM_DATA_W-1:0] referenceWord(input memCtrlPkg::memReq_t r);
        logic [`MEM_DATA_W-1:0] w;
        logic [`RAM_ADDR_W-1:0] idx;
        int                     i;
        w = '0;
        for (i = 0; i < int'(r.len); i++) begin
            idx = r.addr[`RAM_ADDR_W-1:0] + `RAM_ADDR_W'(i);
            w[`BYTE_W*i +: `BYTE_W] = refMem[idx];
        end
        return w;
    endfunction

    task automatic storeReference(input memCtrlPkg::memReq_t r);
        logic [`RAM_ADDR_W-1:0] idx;
        int                     i;
        for (i = 0; i < int'(r.len); i++) begin
            idx = r.addr[`RAM_ADDR_W-1:0] + `RAM_ADDR_W'(i);
            refMem[idx] = r.wdata[`BYTE_W*i +: `BYTE_W];
        end
    endtask

    task automatic checkIdle(input logic [127:0] phase);
        if (fetchDone !== 1'b0 || dataDone !== 1'b0 || busy !== memCtrlPkg::OWN_IDLE) begin
            errors++;
            $display("Mismatch in %0s: expected 0000, actual %b", phase,
                     {fetchDone, dataDone, busy});
        end
    endtask

    task automatic beginTransfer();
        if (pending) begin
            errors++;
            $display("%0s: a transfer started before the previous one finished", testName);
        end
        pending    = 1'b1;
        owner      = busy;
        xferName   = testName;
        xferCycles = 0;
        if (busy == memCtrlPkg::OWN_DATA) begin
            xfer    = dataReq;
            xferExp = expDataCycle;
        end else begin
            xfer.isStore = 1'b0;
            xfer.len     = 3'd4;
            xfer.addr    = fetchAddr;
            xfer.wdata   = '0;
            xferExp      = expFetchCycle;
            if (dataEn) begin
                errors++;
                $display("%0s: fetch was granted while a data request was waiting", testName);
            end
        end
    endtask

    task automatic finishTransfer();
        logic [`MEM_DATA_W-1:0] actual;
        logic [`MEM_DATA_W-1:0] expected;
        if (!pending) begin
            errors++;
            $display("%0s: done pulse arrived with no pending request", testName);
        end else if ((dataDone && owner != memCtrlPkg::OWN_DATA)
                     || (fetchDone && owner != memCtrlPkg::OWN_FETCH)) begin
            errors++;
            $display("%0s: done pulse came on the wrong port", xferName);
        end else begin
            if (!lastAdvance) begin
                errors++;
                $display("%0s: done pulse was raised on a stalled cycle", xferName);
            end
            if (xferCycles + 1 != xferExp) begin
                errors++;
                $display("Mismatch in %0s: expected done in cycle %0d, actual cycle %0d",
                         xferName, xferExp, xferCycles + 1);
            end
            actual = dataDone ? dataRdata : fetchInst;
            if (xfer.isStore) begin
                storeReference(xfer);
            end else begin
                expected = referenceWord(xfer);
                if (actual !== expected) begin
                    errors++;
                    $display("Mismatch in %0s: expected %h, actual %h", xferName, expected, actual);
                end
            end
        end
        pending = 1'b0;
    endtask

    // values read here are the ones held through the cycle just ending
    always @(posedge clk) begin
        if (rst) begin
            if (resetEdges > 0) begin
                checkIdle("reset");
            end
            resetEdges++;
            pending = 1'b0;
        end else begin
            if (lastRst) begin
                checkIdle("after reset");
            end
            if (fetchDone || dataDone) begin
                finishTransfer();
            end
            if (busy != memCtrlPkg::OWN_IDLE && busy != lastBusy) begin
                beginTransfer();
            end
            if (pending && busy != memCtrlPkg::OWN_IDLE) begin
                xferCycles++;
            end
        end
        lastRst     = rst;
        lastBusy    = busy;
        lastAdvance = rdy && !ioBufferFull;
    end

endmodule

//--- verif/tbMemSubsystem.sv
`timescale 1ns/10ps
`include "memCtrl_defs.svh"

module tbMemSubsystem;
    localparam int NUM_TESTS   = 16;
    localparam int MAX_STALL   = 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * (6 + MAX_STALL) + 50;

    localparam logic [1:0] PORT_FETCH = 2'd0;
    localparam logic [1:0] PORT_DATA  = 2'd1;
    localparam logic [1:0] PORT_BOTH  = 2'd2;
    localparam logic [1:0] STALL_NONE = 2'd0;
    localparam logic [1:0] STALL_RDY  = 2'd1;
    localparam logic [1:0] STALL_IO   = 2'd2;

    typedef struct packed {
        logic [127:0]           name;
        logic [1:0]             port;
        logic                   isStore;
        memCtrlPkg::memLen_t    len;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_ADDR_W-1:0] fetchAddr;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [1:0]             stall;
        int                     stallLen;
        int                     expDataCycle;
        int                     expFetchCycle;
    } stimulus_t;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   ioBufferFull;
    logic                   fetchEn;
    logic [`MEM_ADDR_W-1:0] fetchAddr;
    logic                   fetchDone;
    logic [`MEM_DATA_W-1:0] fetchInst;
    logic                   dataEn;
    memCtrlPkg::memReq_t    dataReq;
    logic                   dataDone;
    logic [`MEM_DATA_W-1:0] dataRdata;
    memCtrlPkg::memOwner_t  busy;
    logic [127:0]           testName;
    int                     expDataCycle;
    int                     expFetchCycle;
    int                     checkErrors;
    stimulus_t              tests [NUM_TESTS];
    int                     numTests;
    logic [31:0]            lfsrState;
    int                     cycleCount = 0;

    clockGen #(.PERIOD_NS(100), .RESET_CYCLES(2)) clk_i (.clk(clk), .rst(rst));

    memSubsystem dut_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .busy         (busy)
    );

    memChecker checker_i (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .ioBufferFull  (ioBufferFull),
        .dataEn        (dataEn),
        .dataReq       (dataReq),
        .fetchAddr     (fetchAddr),
        .fetchDone     (fetchDone),
        .fetchInst     (fetchInst),
        .dataDone      (dataDone),
        .dataRdata     (dataRdata),
        .busy          (busy),
        .testName      (testName),
        .expDataCycle  (expDataCycle),
        .expFetchCycle (expFetchCycle),
        .errorCount    (checkErrors)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        repeat (n) begin
            lfsrState = nextLfsr(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic addTest(input logic [127:0] name, input logic [1:0] port,
                           input logic isStore, input memCtrlPkg::memLen_t len,
                           input logic [31:0] addr, input logic [31:0] fAddr,
                           input logic [1:0] stall);
        stimulus_t   t;
        logic [31:0] bits;
        t.name      = name;
        t.port      = port;
        t.isStore   = isStore;
        t.len       = len;
        t.addr      = addr;
        t.fetchAddr = fAddr;
        t.wdata     = '0;
        t.stall     = stall;
        t.stallLen  = 0;
        if (isStore) begin
            takeBits(32, bits);
            t.wdata = bits;
        end
        if (stall != STALL_NONE) begin
            takeBits(3, bits);
            t.stallLen = int'(bits[2:0]) + 1;
        end
        // done cycle: latch, one per byte address, one more on reads
        t.expDataCycle  = (isStore ? int'(len) + 1 : int'(len) + 2) + t.stallLen;
        t.expFetchCycle = 6 + t.stallLen;
        tests[numTests] = t;
        numTests++;
    endtask

    task automatic buildTable();
        addTest("store_word",   PORT_DATA,  1'b1, 3'd4, 32'h100, 32'h0,   STALL_NONE);
        addTest("load_word",    PORT_DATA,  1'b0, 3'd4, 32'h100, 32'h0,   STALL_NONE);
        addTest("store_half",   PORT_DATA,  1'b1, 3'd2, 32'h204, 32'h0,   STALL_NONE);
        addTest("load_half",    PORT_DATA,  1'b0, 3'd2, 32'h204, 32'h0,   STALL_NONE);
        addTest("store_byte",   PORT_DATA,  1'b1, 3'd1, 32'h30b, 32'h0,   STALL_NONE);
        addTest("load_byte",    PORT_DATA,  1'b0, 3'd1, 32'h30b, 32'h0,   STALL_NONE);
        addTest("byte_of_word", PORT_DATA,  1'b0, 3'd1, 32'h102, 32'h0,   STALL_NONE);
        addTest("store_inst",   PORT_DATA,  1'b1, 3'd4, 32'h400, 32'h0,   STALL_NONE);
        addTest("fetch_inst",   PORT_FETCH, 1'b0, 3'd4, 32'h0,   32'h400, STALL_NONE);
        addTest("fetch_word",   PORT_FETCH, 1'b0, 3'd4, 32'h0,   32'h100, STALL_NONE);
        addTest("prio_store",   PORT_BOTH,  1'b1, 3'd4, 32'h500, 32'h400, STALL_NONE);
        addTest("prio_load",    PORT_BOTH,  1'b0, 3'd4, 32'h500, 32'h100, STALL_NONE);
        addTest("stall_rdy",    PORT_DATA,  1'b0, 3'd4, 32'h500, 32'h0,   STALL_RDY);
        addTest("stall_io_st",  PORT_DATA,  1'b1, 3'd2, 32'h600, 32'h0,   STALL_IO);
        addTest("stall_io_ld",  PORT_DATA,  1'b0, 3'd2, 32'h600, 32'h0,   STALL_IO);
        addTest("stall_fetch",  PORT_FETCH, 1'b0, 3'd4, 32'h0,   32'h500, STALL_RDY);
    endtask

    task automatic applyStall(input logic [1:0] kind, input logic on);
        rdy          = !(on && kind == STALL_RDY);
        ioBufferFull = on && kind == STALL_IO;
    endtask

    // hold en until the matching done, stall from the second cycle on
    task automatic runEntry(input stimulus_t s);
        int   cyc;
        logic waitData;
        logic waitFetch;
        @(negedge clk);
        waitData        = (s.port != PORT_FETCH);
        waitFetch       = (s.port != PORT_DATA);
        testName        = s.name;
        expDataCycle    = s.expDataCycle;
        expFetchCycle   = s.expFetchCycle;
        dataReq.isStore = s.isStore;
        dataReq.len     = s.len;
        dataReq.addr    = s.addr;
        dataReq.wdata   = s.wdata;
        fetchAddr       = s.fetchAddr;
        dataEn          = waitData;
        fetchEn         = waitFetch;
        cyc             = 0;
        while (waitData || waitFetch) begin
            @(negedge clk);
            cyc++;
            if (s.stall != STALL_NONE && cyc == 2) begin
                applyStall(s.stall, 1'b1);
            end
            if (s.stall != STALL_NONE && cyc == 2 + s.stallLen) begin
                applyStall(s.stall, 1'b0);
            end
            if (dataDone) begin
                dataEn   = 1'b0;
                waitData = 1'b0;
            end
            if (fetchDone) begin
                fetchEn   = 1'b0;
                waitFetch = 1'b0;
            end
        end
        applyStall(s.stall, 1'b0);
    endtask

    initial begin
        rdy           = 1'b1;
        ioBufferFull  = 1'b0;
        fetchEn       = 1'b0;
        fetchAddr     = '0;
        dataEn        = 1'b0;
        dataReq       = '0;
        testName      = "idle";
        expDataCycle  = 0;
        expFetchCycle = 0;
        lfsrState     = 32'he018;
        numTests      = 0;
        buildTable();
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        for (int i = 0; i < numTests; i++) begin
            runEntry(tests[i]);
        end
        repeat (4) @(negedge clk);
        $display("Errors: %0d", checkErrors);
        if (checkErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d", checkErrors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

//--- memSubsystem.f
+incdir+src
src/memCtrlPkg.sv
src/memArbiter.sv
src/byteSequencer.sv
src/byteRam.sv
src/memSubsystem.sv
verif/clockGen.sv
verif/memChecker.sv
verif/tbMemSubsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMemSubsystem
FILELIST  ?= memSubsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
